/* files.f */
hw/axi_pkg.sv
hw/mem_port_pkg.sv
hw/mem_port_agent.sv
hw/axi_request_arbiter.sv
hw/axi_response_router.sv
hw/mem_subsystem_top.sv
sim/tb_clock_gen.sv
sim/mem_subsystem_properties.sv
sim/tb_mem_subsystem.sv

/* hw/axi_pkg.sv */
package axi_pkg;

    // ***********************************************************
    // field widths of the AXI3 master
    // ***********************************************************
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;   // one strobe per byte lane
    localparam int unsigned ID_W   = 4;            // carries the CPU port index

    // ***********************************************************
    // fixed burst encodings, every transfer is one beat
    // ***********************************************************
    localparam logic [3:0] AXLEN_SINGLE = 4'd0;    // len counts beats minus one
    localparam logic [2:0] AXSIZE_WORD  = 3'b010;  // log2 of four bytes per beat
    localparam logic [1:0] AXBURST_INCR = 2'b01;

endpackage

/* hw/axi_request_arbiter.sv */
module axi_request_arbiter (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,

    input  logic [mem_port_pkg::NUM_PORTS-1:0]                     push_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::STRB_W-1:0] push_wen_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::ADDR_W-1:0] push_addr_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::DATA_W-1:0] push_wdata_i,
    output logic [mem_port_pkg::NUM_PORTS-1:0]                     credit_o,

    output logic [axi_pkg::ID_W-1:0]                               arid_o,
    output logic [axi_pkg::ADDR_W-1:0]                             araddr_o,
    output logic                                                   arvalid_o,
    input  logic                                                   arready_i,

    output logic [axi_pkg::ID_W-1:0]                               awid_o,
    output logic [axi_pkg::ADDR_W-1:0]                             awaddr_o,
    output logic                                                   awvalid_o,
    input  logic                                                   awready_i,

    output logic [axi_pkg::ID_W-1:0]                               wid_o,
    output logic [axi_pkg::DATA_W-1:0]                             wdata_o,
    output logic [axi_pkg::STRB_W-1:0]                             wstrb_o,
    output logic                                                   wlast_o,
    output logic                                                   wvalid_o,
    input  logic                                                   wready_i
);

    import axi_pkg::*;
    import mem_port_pkg::*;

    // ***********************************************************
    // request buffers, one small FIFO per port
    // ***********************************************************
    logic [STRB_W-1:0]    buf_wen   [NUM_PORTS][BUF_DEPTH];
    logic [ADDR_W-1:0]    buf_addr  [NUM_PORTS][BUF_DEPTH];
    logic [DATA_W-1:0]    buf_wdata [NUM_PORTS][BUF_DEPTH];
    logic [BUF_PTR_W-1:0] wr_ptr    [NUM_PORTS];
    logic [BUF_PTR_W-1:0] rd_ptr    [NUM_PORTS];
    logic [CREDIT_W-1:0]  count     [NUM_PORTS];

    logic [PORT_W-1:0]    sel;      // round-robin owner of the AXI channels
    logic [PORT_W-1:0]    nxt;
    logic [PORT_W-1:0]    cand;
    logic                 aw_done;
    logic                 w_done;
    logic                 head_valid;
    logic                 head_rd;
    logic [STRB_W-1:0]    head_wen;
    logic [ADDR_W-1:0]    head_addr;
    logic                 pop;

    function automatic logic [BUF_PTR_W-1:0] next_ptr(input logic [BUF_PTR_W-1:0] ptr);
        return (ptr == BUF_PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (push_i[p]) begin
                buf_wen[p][wr_ptr[p]]   <= push_wen_i[p];
                buf_addr[p][wr_ptr[p]]  <= push_addr_i[p];
                buf_wdata[p][wr_ptr[p]] <= push_wdata_i[p];
            end
        end
    end

    // ***********************************************************
    // head of the selected port drives AR or AW plus W
    // ***********************************************************
    assign head_valid = (count[sel] != '0);
    assign head_wen   = buf_wen[sel][rd_ptr[sel]];
    assign head_rd    = (head_wen == '0);
    // clear the byte offset below the beat size
    assign head_addr  = buf_addr[sel][rd_ptr[sel]] & ~((ADDR_W'(1) << AXSIZE_WORD) - 1'b1);

    assign arvalid_o = head_valid && head_rd;
    assign arid_o    = ID_W'(sel);
    assign araddr_o  = head_addr;

    assign awvalid_o = head_valid && !head_rd && !aw_done;
    assign awid_o    = ID_W'(sel);
    assign awaddr_o  = head_addr;

    assign wvalid_o  = head_valid && !head_rd && !w_done;
    assign wid_o     = ID_W'(sel);
    assign wdata_o   = buf_wdata[sel][rd_ptr[sel]];
    assign wstrb_o   = head_wen;
    assign wlast_o   = (AXLEN_SINGLE == '0);  // single beat, so the first beat is the last

    // AW and W may finish in either order
    assign pop = head_valid && (head_rd ? arready_i
                                        : ((aw_done || awready_i) && (w_done || wready_i)));

    assign credit_o = pop ? (NUM_PORTS'(1) << sel) : '0;

    always_comb begin
        nxt  = sel;
        cand = sel;
        // walk backwards so the closest non-empty port wins
        for (int k = NUM_PORTS - 1; k >= 1; k--) begin
            cand = PORT_W'((int'(sel) + k) % NUM_PORTS);
            if (count[cand] != '0) begin
                nxt = cand;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            sel     <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (push_i[p]) begin
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                end
                if (credit_o[p]) begin
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                end
                count[p] <= count[p] + CREDIT_W'(push_i[p]) - CREDIT_W'(credit_o[p]);
            end
            if (pop || !head_valid) begin
                sel <= nxt;  // never moves while a valid is up
            end
            aw_done <= !pop && (aw_done || (awvalid_o && awready_i));
            w_done  <= !pop && (w_done || (wvalid_o && wready_i));
        end
    end

endmodule

/* hw/axi_response_router.sv */
module axi_response_router #(
    parameter int unsigned N_PORTS = 2
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,

    input  logic [axi_pkg::ID_W-1:0]                 rid_i,
    input  logic [axi_pkg::DATA_W-1:0]               rdata_i,
    input  logic                                     rvalid_i,
    output logic                                     rready_o,

    input  logic [axi_pkg::ID_W-1:0]                 bid_i,
    input  logic                                     bvalid_i,
    output logic                                     bready_o,

    output logic [N_PORTS-1:0]                       rsp_rvalid_o,
    output logic [N_PORTS-1:0][axi_pkg::DATA_W-1:0]  rsp_rdata_o,
    output logic [N_PORTS-1:0]                       rsp_bvalid_o
);

    import axi_pkg::*;

    // agents never refuse a response once out of reset
    assign rready_o = rst_n_i;
    assign bready_o = rst_n_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_rvalid_o <= '0;
            rsp_bvalid_o <= '0;
        end else begin
            // an ID outside the port range matches no port and is dropped
            for (int p = 0; p < N_PORTS; p++) begin
                rsp_rvalid_o[p] <= rvalid_i && rready_o && (rid_i == ID_W'(p));
                rsp_bvalid_o[p] <= bvalid_i && bready_o && (bid_i == ID_W'(p));
            end
        end
    end

    // read data is captured only by the port that owns the beat
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < N_PORTS; p++) begin
            if (rvalid_i && rready_o && (rid_i == ID_W'(p))) begin
                rsp_rdata_o[p] <= rdata_i;
            end
        end
    end

endmodule

/* hw/mem_port_agent.sv */
module mem_port_agent (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       cpu_req_i,
    input  logic [axi_pkg::STRB_W-1:0] cpu_wen_i,
    input  logic [axi_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [axi_pkg::DATA_W-1:0] cpu_wdata_i,
    output logic                       cpu_done_o,
    output logic [axi_pkg::DATA_W-1:0] cpu_rdata_o,

    output logic                       push_o,
    output logic [axi_pkg::STRB_W-1:0] push_wen_o,
    output logic [axi_pkg::ADDR_W-1:0] push_addr_o,
    output logic [axi_pkg::DATA_W-1:0] push_wdata_o,
    input  logic                       credit_i,

    input  logic                       rsp_rvalid_i,
    input  logic [axi_pkg::DATA_W-1:0] rsp_rdata_i,
    input  logic                       rsp_bvalid_i
);

    import axi_pkg::*;
    import mem_port_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic [WR_CNT_W-1:0] wr_pend;   // posted writes not yet answered on B
    logic                rd_busy;
    logic                issued;    // current CPU request already handed over
    logic                wr_done_q;
    logic                is_read;
    logic                order_ok;

    assign is_read = (cpu_wen_i == '0);

    // a read waits for all earlier writes, a write only for room in the counter
    assign order_ok = is_read ? (wr_pend == '0) : (wr_pend != '1);

    assign push_o = cpu_req_i && !issued && !rd_busy && (credits != '0) && order_ok;

    assign push_wen_o   = cpu_wen_i;
    assign push_addr_o  = cpu_addr_i;
    assign push_wdata_o = cpu_wdata_i;

    // writes are posted, reads end with the routed R pulse
    assign cpu_done_o  = wr_done_q || (rd_busy && rsp_rvalid_i);
    assign cpu_rdata_o = rsp_rdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits   <= CREDIT_W'(BUF_DEPTH);
            wr_pend   <= '0;
            rd_busy   <= 1'b0;
            issued    <= 1'b0;
            wr_done_q <= 1'b0;
        end else begin
            credits   <= credits - CREDIT_W'(push_o) + CREDIT_W'(credit_i);
            wr_pend   <= wr_pend + WR_CNT_W'(push_o && !is_read) - WR_CNT_W'(rsp_bvalid_i);
            wr_done_q <= push_o && !is_read;

            if (push_o && is_read) begin
                rd_busy <= 1'b1;
            end else if (rsp_rvalid_i) begin
                rd_busy <= 1'b0;
            end

            // the CPU still holds the request in the done cycle
            if (push_o) begin
                issued <= 1'b1;
            end else if (cpu_done_o) begin
                issued <= 1'b0;
            end
        end
    end

endmodule

/* hw/mem_port_pkg.sv */
package mem_port_pkg;

    // two CPU ports, port 0 fetches instructions and port 1 moves data
    localparam int unsigned NUM_PORTS = 2;
    localparam int unsigned PORT_W    = $clog2(NUM_PORTS);

    // request buffer per port inside the arbiter
    localparam int unsigned BUF_DEPTH = 2;
    localparam int unsigned BUF_PTR_W = $clog2(BUF_DEPTH);

    // a credit counter holds 0 up to BUF_DEPTH
    localparam int unsigned CREDIT_W  = $clog2(BUF_DEPTH + 1);

    // posted writes still waiting for their B response
    localparam int unsigned WR_CNT_W  = 3;

endpackage

/* hw/mem_subsystem_top.sv */
module mem_subsystem_top (
    input  logic                                                   clk_i,
    input  logic                                                   rst_n_i,

    // CPU ports, index 0 fetches and index 1 is data
    input  logic [mem_port_pkg::NUM_PORTS-1:0]                     cpu_req_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::STRB_W-1:0] cpu_wen_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::DATA_W-1:0] cpu_wdata_i,
    output logic [mem_port_pkg::NUM_PORTS-1:0]                     cpu_done_o,
    output logic [mem_port_pkg::NUM_PORTS-1:0][axi_pkg::DATA_W-1:0] cpu_rdata_o,

    output logic [axi_pkg::ID_W-1:0]                               arid_o,
    output logic [axi_pkg::ADDR_W-1:0]                             araddr_o,
    output logic                                                   arvalid_o,
    input  logic                                                   arready_i,

    input  logic [axi_pkg::ID_W-1:0]                               rid_i,
    input  logic [axi_pkg::DATA_W-1:0]                             rdata_i,
    input  logic [1:0]                                             rresp_i,
    input  logic                                                   rlast_i,
    input  logic                                                   rvalid_i,
    output logic                                                   rready_o,

    output logic [axi_pkg::ID_W-1:0]                               awid_o,
    output logic [axi_pkg::ADDR_W-1:0]                             awaddr_o,
    output logic                                                   awvalid_o,
    input  logic                                                   awready_i,

    output logic [axi_pkg::ID_W-1:0]                               wid_o,
    output logic [axi_pkg::DATA_W-1:0]                             wdata_o,
    output logic [axi_pkg::STRB_W-1:0]                             wstrb_o,
    output logic                                                   wlast_o,
    output logic                                                   wvalid_o,
    input  logic                                                   wready_i,

    input  logic [axi_pkg::ID_W-1:0]                               bid_i,
    input  logic [1:0]                                             bresp_i,
    input  logic                                                   bvalid_i,
    output logic                                                   bready_o
);

    import axi_pkg::*;
    import mem_port_pkg::*;

    logic [NUM_PORTS-1:0]             push;
    logic [NUM_PORTS-1:0][STRB_W-1:0] push_wen;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] push_addr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] push_wdata;
    logic [NUM_PORTS-1:0]             credit;
    logic [NUM_PORTS-1:0]             rsp_rvalid;
    logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_rdata;
    logic [NUM_PORTS-1:0]             rsp_bvalid;

    axi_response_router #(.N_PORTS(NUM_PORTS)) u_router (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rid_i        (rid_i),
        .rdata_i      (rdata_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .bid_i        (bid_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .rsp_rvalid_o (rsp_rvalid),
        .rsp_rdata_o  (rsp_rdata),
        .rsp_bvalid_o (rsp_bvalid)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        mem_port_agent u_agent (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .cpu_req_i    (cpu_req_i[p]),
            .cpu_wen_i    (cpu_wen_i[p]),
            .cpu_addr_i   (cpu_addr_i[p]),
            .cpu_wdata_i  (cpu_wdata_i[p]),
            .cpu_done_o   (cpu_done_o[p]),
            .cpu_rdata_o  (cpu_rdata_o[p]),
            .push_o       (push[p]),
            .push_wen_o   (push_wen[p]),
            .push_addr_o  (push_addr[p]),
            .push_wdata_o (push_wdata[p]),
            .credit_i     (credit[p]),
            .rsp_rvalid_i (rsp_rvalid[p]),
            .rsp_rdata_i  (rsp_rdata[p]),
            .rsp_bvalid_i (rsp_bvalid[p])
        );
    end

    axi_request_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_wen_i   (push_wen),
        .push_addr_i  (push_addr),
        .push_wdata_i (push_wdata),
        .credit_o     (credit),
        .arid_o       (arid_o),
        .araddr_o     (araddr_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .awid_o       (awid_o),
        .awaddr_o     (awaddr_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wid_o        (wid_o),
        .wdata_o      (wdata_o),
        .wstrb_o      (wstrb_o),
        .wlast_o      (wlast_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mem_subsystem -f files.f \
    && obj_dir/Vtb_mem_subsystem +verilator+error+limit+100 | tee /dev/stderr \
    | grep -x "TESTBENCH PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/mem_subsystem_properties.sv */
module mem_subsystem_properties (
    input logic                                clk_i,
    input logic                                rst_n_i,
    input logic [mem_port_pkg::NUM_PORTS-1:0]  cpu_done_i,
    input logic [mem_port_pkg::NUM_PORTS-1:0]  credit_i,
    input logic [axi_pkg::ID_W-1:0]            arid_i,
    input logic [axi_pkg::ADDR_W-1:0]          araddr_i,
    input logic                                arvalid_i,
    input logic                                arready_i,
    input logic [axi_pkg::ID_W-1:0]            awid_i,
    input logic [axi_pkg::ADDR_W-1:0]          awaddr_i,
    input logic                                awvalid_i,
    input logic                                awready_i,
    input logic [axi_pkg::DATA_W-1:0]          wdata_i,
    input logic [axi_pkg::STRB_W-1:0]          wstrb_i,
    input logic                                wlast_i,
    input logic                                wvalid_i,
    input logic                                wready_i
);

    int unsigned fail_cnt = 0;   // read by the testbench monitor
    logic        any_hs;

    assign any_hs = (arvalid_i && arready_i) || (awvalid_i && awready_i) || (wvalid_i && wready_i);

    // ***********************************************************
    // reset state and AXI channel stability
    // ***********************************************************
    reset_idle: assert property (@(posedge clk_i)
        !rst_n_i |=> !arvalid_i && !awvalid_i && !wvalid_i && (cpu_done_i == '0))
        else begin fail_cnt++; $error("valid or cpu done high right after reset"); end

    ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arid_i))
        else begin fail_cnt++; $error("AR channel changed before arready"); end

    aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awid_i))
        else begin fail_cnt++; $error("AW channel changed before awready"); end

    w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
        else begin fail_cnt++; $error("W channel changed before wready"); end

    w_last: assert property (@(posedge clk_i) disable iff (!rst_n_i) wvalid_i |-> wlast_i)
        else begin fail_cnt++; $error("wlast low on a single beat write"); end

    // ***********************************************************
    // a credit only comes back with the handshake that pops its entry
    // ***********************************************************
    credit_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (credit_i != '0) |-> $onehot(credit_i) && any_hs)
        else begin fail_cnt++; $error("credit returned without a pop handshake"); end

endmodule

bind mem_subsystem_top mem_subsystem_properties u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cpu_done_i (cpu_done_o),
    .credit_i   (credit),
    .arid_i     (arid_o),
    .araddr_i   (araddr_o),
    .arvalid_i  (arvalid_o),
    .arready_i  (arready_i),
    .awid_i     (awid_o),
    .awaddr_i   (awaddr_o),
    .awvalid_i  (awvalid_o),
    .awready_i  (awready_i),
    .wdata_i    (wdata_o),
    .wstrb_i    (wstrb_o),
    .wlast_i    (wlast_o),
    .wvalid_i   (wvalid_o),
    .wready_i   (wready_i)
);

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int unsigned PERIOD     = 20,
    parameter int unsigned RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset lets go just after its last edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

/* sim/tb_mem_subsystem.sv */
module tb_mem_subsystem;

    import axi_pkg::*;
    import mem_port_pkg::*;

    localparam logic [31:0] SEED    = 32'd12;
    localparam int unsigned TIMEOUT = 200;   // cycles one wait may take
    localparam int unsigned NUM_OPS = 40;    // random operations per port

    logic clk;
    logic rst_n;
    logic [NUM_PORTS-1:0]             cpu_req;
    logic [NUM_PORTS-1:0][STRB_W-1:0] cpu_wen;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] cpu_addr;
    logic [NUM_PORTS-1:0][DATA_W-1:0] cpu_wdata;
    logic [NUM_PORTS-1:0]             cpu_done;
    logic [NUM_PORTS-1:0][DATA_W-1:0] cpu_rdata;
    logic [ID_W-1:0]   arid, rid, awid, wid, bid;
    logic [ADDR_W-1:0] araddr, awaddr;
    logic [DATA_W-1:0] rdata, wdata;
    logic [STRB_W-1:0] wstrb;
    logic [1:0]        rresp, bresp;
    logic arvalid, arready, rvalid, rready, rlast, awvalid, awready;
    logic wvalid, wready, wlast, bvalid, bready;
    logic              hold_aw;            // keeps awready low for the credit test
    logic [31:0]       stim_rng;
    int unsigned       done_cnt;
    logic [DATA_W-1:0] ref_mem   [256];    // word index is addr[9:2]
    logic [DATA_W-1:0] slave_mem [256];

    tb_clock_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

    mem_subsystem_top u_dut (
        .clk_i (clk), .rst_n_i (rst_n),
        .cpu_req_i (cpu_req), .cpu_wen_i (cpu_wen), .cpu_addr_i (cpu_addr),
        .cpu_wdata_i (cpu_wdata), .cpu_done_o (cpu_done), .cpu_rdata_o (cpu_rdata),
        .arid_o (arid), .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
        .rid_i (rid), .rdata_i (rdata), .rresp_i (rresp), .rlast_i (rlast),
        .rvalid_i (rvalid), .rready_o (rready),
        .awid_o (awid), .awaddr_o (awaddr), .awvalid_o (awvalid), .awready_i (awready),
        .wid_o (wid), .wdata_o (wdata), .wstrb_o (wstrb), .wlast_o (wlast),
        .wvalid_o (wvalid), .wready_i (wready),
        .bid_i (bid), .bresp_i (bresp), .bvalid_i (bvalid), .bready_o (bready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input int unsigned idx);
        return (32'h9E37_79B9 * 32'(idx + 1)) ^ 32'h5A5A_0000;
    endfunction

    task automatic halt_failed();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
        halt_failed();
    endtask

    task automatic timed_out(input string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        halt_failed();
    endtask

    // called 2 units after a rising edge, returns at the same point of a later cycle
    task automatic cpu_access(input int p, input logic [STRB_W-1:0] wen,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int unsigned waited;
        logic [7:0]  w;
        w = addr[9:2];
        cpu_req[p]   = 1'b1;
        cpu_wen[p]   = wen;
        cpu_addr[p]  = addr;
        cpu_wdata[p] = data;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) timed_out($sformatf("cpu_done_o[%0d]", p));
        end while (!cpu_done[p]);
        if (wen == '0) begin
            assert (cpu_rdata[p] == ref_mem[w])
                else mismatch($sformatf("cpu_rdata_o[%0d]", p), cpu_rdata[p], ref_mem[w]);
        end else begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wen[b]) ref_mem[w][8*b +: 8] = data[8*b +: 8];
            end
        end
        @(posedge clk);
        #2;
        cpu_req[p] = 1'b0;
    endtask

    // each port stays inside its own 128 byte window, so ID routing shows in the data
    task automatic random_traffic(input int p, input int unsigned n);
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        for (int unsigned i = 0; i < n; i++) begin
            stim_rng = lcg_step(stim_rng);
            r = stim_rng;
            addr = ((p == 0) ? 32'h000 : 32'h200) + ADDR_W'({r[22:18], 2'b00});
            stim_rng = lcg_step(stim_rng);
            cpu_access(p, r[16] ? r[27:24] : 4'h0, addr, stim_rng);
        end
    endtask

    // ***********************************************************
    // AXI slave memory with random latency and stalls
    // ***********************************************************
    initial begin : axi_slave
        logic [31:0]       rng;
        int unsigned       cycle;
        logic [ID_W-1:0]   r_id_q[$], aw_id_q[$], w_id_q[$], b_id_q[$];
        logic [DATA_W-1:0] r_data_q[$], w_data_q[$];
        logic [ADDR_W-1:0] aw_addr_q[$];
        logic [STRB_W-1:0] w_strb_q[$];
        int unsigned       r_due_q[$], b_due_q[$];
        logic [7:0]        w_idx;
        logic [ID_W-1:0]   w_port;
        rng = SEED;
        cycle = 0;
        {arready, awready, wready, rvalid, bvalid} = '0;
        {rid, rdata, rresp, bid, bresp} = '0;
        rlast = 1'b1;
        for (int i = 0; i < 256; i++) slave_mem[i] = fill_word(i);
        forever begin
            @(negedge clk);
            cycle++;
            rng = lcg_step(rng);
            if (rst_n) begin
                assert (rready) else mismatch("rready_o", 32'(rready), 32'd1);
                assert (bready) else mismatch("bready_o", 32'(bready), 32'd1);
            end
            if (arvalid && arready) begin
                r_id_q.push_back(arid);
                r_data_q.push_back(slave_mem[araddr[9:2]]);
                r_due_q.push_back(cycle + int'(rng[17:16]));
            end
            if (awvalid && awready) begin
                aw_id_q.push_back(awid);
                aw_addr_q.push_back(awaddr);
            end
            if (wvalid && wready) begin
                w_id_q.push_back(wid);
                w_data_q.push_back(wdata);
                w_strb_q.push_back(wstrb);
            end
            if (rvalid && rready) begin
                void'(r_id_q.pop_front());
                void'(r_data_q.pop_front());
                void'(r_due_q.pop_front());
            end
            if (bvalid && bready) begin
                void'(b_id_q.pop_front());
                void'(b_due_q.pop_front());
            end
            if (aw_addr_q.size() != 0 && w_data_q.size() != 0) begin
                w_idx = aw_addr_q[0][9:2];
                w_port = ID_W'(aw_addr_q[0][9]);   // port 1 owns every address with bit 9 set
                assert (w_id_q[0] == w_port)
                    else mismatch("wid_o", 32'(w_id_q[0]), 32'(w_port));
                for (int b = 0; b < STRB_W; b++) begin
                    if (w_strb_q[0][b]) slave_mem[w_idx][8*b +: 8] = w_data_q[0][8*b +: 8];
                end
                b_id_q.push_back(aw_id_q.pop_front());
                b_due_q.push_back(cycle + int'(rng[19:18]));
                void'(aw_addr_q.pop_front());
                void'(w_id_q.pop_front());
                void'(w_data_q.pop_front());
                void'(w_strb_q.pop_front());
            end
            @(posedge clk);
            #2;
            rvalid = (r_due_q.size() != 0) && (r_due_q[0] <= cycle);
            if (r_due_q.size() != 0) {rid, rdata} = {r_id_q[0], r_data_q[0]};
            bvalid = (b_due_q.size() != 0) && (b_due_q[0] <= cycle);
            if (b_due_q.size() != 0) bid = b_id_q[0];
            arready = (rng[22:20] != 3'd0);   // roughly one stall in eight cycles
            awready = !hold_aw && (rng[25:23] != 3'd0);
            wready  = (rng[28:26] != 3'd0);
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_props.fail_cnt != 0) begin
            $display("a bus property failed, see the assertion message above");
            halt_failed();
        end
    end

    // ***********************************************************
    // stimulus sequence
    // ***********************************************************
    initial begin : stimulus
        int unsigned waited;
        {cpu_req, cpu_wen, cpu_addr, cpu_wdata} = '0;
        hold_aw  = 1'b0;
        stim_rng = SEED;
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
        waited = 0;
        while (!rst_n) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) timed_out("reset release");
        end
        #2;
        cpu_access(1, 4'hF, 32'h240, 32'h1234_5678);   // read after write on the same port
        cpu_access(1, 4'h0, 32'h240, 32'h0);
        cpu_access(0, 4'b0101, 32'h040, 32'hAABB_CCDD);   // byte merges
        cpu_access(0, 4'b1000, 32'h040, 32'h1100_0000);
        cpu_access(0, 4'h0, 32'h040, 32'h0);
        fork
            random_traffic(0, NUM_OPS);
            random_traffic(1, NUM_OPS);
        join
        // the reads drain every posted write, so all credits are back
        cpu_access(0, 4'h0, 32'h000, 32'h0);
        cpu_access(1, 4'h0, 32'h300, 32'h0);
        hold_aw = 1'b1;
        @(posedge clk);
        #2;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    cpu_access(1, 4'hF, 32'h300 + 32'(4 * i), fill_word(i) ^ 32'hFFFF_0000);
                end
            end
            begin
                done_cnt = 0;
                repeat (16) begin
                    @(negedge clk);
                    if (cpu_done[1]) done_cnt++;
                end
                assert (done_cnt == BUF_DEPTH)
                    else mismatch("cpu_done_o[1] pulses", 32'(done_cnt), 32'(BUF_DEPTH));
                hold_aw = 1'b0;
            end
        join
        for (int i = 0; i < 4; i++) cpu_access(1, 4'h0, 32'h300 + 32'(4 * i), 32'h0);
        if (u_dut.u_props.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("a bus property failed during the run");
            halt_failed();
        end
    end

endmodule
